/* Makefile */
SRCS = $(wildcard rtl/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vnird_tb: $(SRCS) files.f
	verilator --binary --timing --assert --top-module nird_tb -f files.f

run: obj_dir/Vnird_tb
	-./obj_dir/Vnird_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/nird_clk_gen.sv */
`timescale 1ns/1ps

module nird_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release on a falling edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* bench/nird_tb.sv */
`timescale 1ns/1ps

module nird_tb;

  localparam int ROWS = nird_geom_pkg::ROWS;
  localparam int COLS = nird_geom_pkg::COLS;
  localparam int FRAME_PIX = ROWS * COLS;
  // windows need four rows and four columns of history
  localparam int WIN_PER_FRAME = (ROWS - 4) * (COLS - 4);
  localparam int LATENCY = 4;
  localparam int MAX_GAP = 3;
  localparam int NUM_TESTS = 3;
  localparam int NUM_FRAMES = 6;
  localparam int DRAIN_CYCLES = 16;
  localparam int NONUNIFORM = 9;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_PIX * (MAX_GAP + 1) +
                                   NUM_TESTS * (LATENCY + DRAIN_CYCLES) + 200;

  // radius-2 offsets (row, col) in angle order with rows growing downward
  localparam int DR[8] = '{0, -2, -2, -2, 0, 2, 2, 2};
  localparam int DC[8] = '{2, 2, 0, -2, -2, -2, 0, 2};

  logic                 clk;
  logic                 rst_n;
  nird_geom_pkg::pix_t  pixel;
  logic                 pixel_valid;
  nird_code_pkg::code_t ni_code;
  nird_code_pkg::code_t rd_code;
  logic                 code_valid;
  logic                 frame_done;

  nird_geom_pkg::pix_t frame_mem [FRAME_PIX];
  int                  exp_ni_q[$];
  int                  exp_rd_q[$];
  int                  accept_q[$];
  int                  seed;
  int                  cycle = 0;
  int                  code_count = 0;
  string               test_name = "reset";

  nird_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  nird_top UUT (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .pixel_i       (pixel),
    .pixel_valid_i (pixel_valid),
    .ni_code_o     (ni_code),
    .rd_code_o     (rd_code),
    .code_valid_o  (code_valid),
    .frame_done_o  (frame_done)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string test, input string what,
                             input int expected, input int actual);
    if (expected !== actual) begin
      $display("ERROR %s: %s expected %0d actual %0d", test, what, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s: %s", test_name, reason);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  function automatic int pixel_at(input int row, input int col);
    return int'(frame_mem[row * COLS + col]);
  endfunction

  // ones count when at most two circular transitions and non-uniform otherwise
  function automatic int uniform_code(input logic [7:0] pat);
    logic [7:0] rot;
    int         trans;
    int         ones;
    // bit k of rot is bit k+1 of the pattern
    rot   = {pat[0], pat[7:1]};
    trans = $countones(pat ^ rot);
    ones  = $countones(pat);
    if (trans <= 2) begin
      return ones;
    end else begin
      return NONUNIFORM;
    end
  endfunction

  // expected code pairs for the stored frame in raster order of the bottom-right pixel
  function automatic void predict_frame();
    int         cr;
    int         cc;
    int         sum;
    int         s2;
    int         s1;
    logic [7:0] ni_pat;
    logic [7:0] rd_pat;
    for (int r = 4; r < ROWS; r++) begin
      for (int c = 4; c < COLS; c++) begin
        cr  = r - 2;
        cc  = c - 2;
        sum = 0;
        for (int dr = -2; dr <= 2; dr++) begin
          for (int dc = -2; dc <= 2; dc++) begin
            sum = sum + pixel_at(cr + dr, cc + dc);
          end
        end
        for (int k = 0; k < 8; k++) begin
          s2        = pixel_at(cr + DR[k], cc + DC[k]);
          s1        = pixel_at(cr + DR[k] / 2, cc + DC[k] / 2);
          ni_pat[k] = (25 * s2 >= sum);
          rd_pat[k] = (s2 >= s1);
        end
        exp_ni_q.push_back(uniform_code(ni_pat));
        exp_rd_q.push_back(uniform_code(rd_pat));
      end
    end
  endfunction

  function automatic void fill_flat(input nird_geom_pkg::pix_t value);
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_mem[i] = value;
    end
  endfunction

  function automatic void fill_random();
    int rnd;
    for (int i = 0; i < FRAME_PIX; i++) begin
      rnd          = $random(seed);
      frame_mem[i] = rnd[7:0];
    end
  endfunction

  // one frame in raster order with up to max_gap idle cycles before each pixel
  task automatic send_frame(input int max_gap);
    int rnd;
    int gap;
    for (int i = 0; i < FRAME_PIX; i++) begin
      if (max_gap > 0) begin
        rnd = $random(seed);
        gap = (rnd & 32'h7fff_ffff) % (max_gap + 1);
        repeat (gap) begin
          // junk data while idle
          pixel       = rnd[15:8];
          pixel_valid = 1'b0;
          @(negedge clk);
        end
      end
      pixel       = frame_mem[i];
      pixel_valid = 1'b1;
      if (max_gap == 0 && i / COLS >= 4 && i % COLS >= 4) begin
        accept_q.push_back(cycle);
      end
      @(negedge clk);
    end
    pixel_valid = 1'b0;
  endtask

  task automatic wait_codes_done();
    while (exp_ni_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (DRAIN_CYCLES) @(negedge clk);
  endtask

  // outputs only move on the rising edge so they are sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (frame_done && !code_valid) begin
        abort_run("frame_done_o high without a code");
      end
      if (code_valid) begin
        if (exp_ni_q.size() == 0) begin
          abort_run("code_valid_o high with no window pending");
        end
        code_count = code_count + 1;
        check_value(test_name, "ni code", exp_ni_q.pop_front(), int'(ni_code));
        check_value(test_name, "rd code", exp_rd_q.pop_front(), int'(rd_code));
        check_value(test_name, "frame done", int'(code_count % WIN_PER_FRAME == 0),
                    int'(frame_done));
        if (accept_q.size() != 0) begin
          check_value(test_name, "latency", LATENCY, cycle - accept_q.pop_front());
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: codes stopped arriving, %0d of %0d received",
             code_count, NUM_FRAMES * WIN_PER_FRAME);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    pixel       = '0;
    pixel_valid = 1'b0;
    seed        = 32'h8405_0c15;
    @(posedge rst_n);
    @(negedge clk);

    // all patterns all ones so every code is 8
    test_name = "flat_frame";
    fill_flat(8'h5a);
    predict_frame();
    for (int i = 0; i < WIN_PER_FRAME; i++) begin
      check_value(test_name, "model ni code", 8, exp_ni_q[i]);
      check_value(test_name, "model rd code", 8, exp_rd_q[i]);
    end
    send_frame(0);
    wait_codes_done();

    test_name = "random_gap_free";
    repeat (3) begin
      fill_random();
      predict_frame();
      send_frame(0);
    end
    wait_codes_done();

    test_name = "random_gaps";
    repeat (2) begin
      fill_random();
      predict_frame();
      send_frame(MAX_GAP);
    end
    wait_codes_done();

    if (exp_ni_q.size() == 0 && exp_rd_q.size() == 0 && accept_q.size() == 0 &&
        code_count == NUM_FRAMES * WIN_PER_FRAME) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("code count %0d, expected %0d, %0d still pending",
               code_count, NUM_FRAMES * WIN_PER_FRAME, exp_ni_q.size());
      $display("CHECKS FAILED");
      $fatal(1, "code count or pending queues wrong at end of run");
    end
  end

endmodule

/* files.f */
rtl/nird_geom_pkg.sv
rtl/nird_code_pkg.sv
rtl/nird_window.sv
rtl/nird_ni_encoder.sv
rtl/nird_rd_encoder.sv
rtl/nird_riu2_map.sv
rtl/nird_top.sv
bench/nird_clk_gen.sv
bench/nird_tb.sv

/* rtl/nird_code_pkg.sv */
package nird_code_pkg;

  // one pattern bit per angle, bit 0 at 0 degrees, counter-clockwise
  localparam int PAT_W = 8;

  // 25 * 255 fits in 13 bits
  localparam int SUM_W = 13;

  localparam int CODE_W = 4;

  typedef logic [PAT_W-1:0] pat_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [CODE_W-1:0] code_t;

  // number of pixels in the patch, scales a sample to the patch sum
  localparam sum_t GAIN = sum_t'(25);

  // largest patch sum for 8-bit pixels
  localparam sum_t SUM_MAX = sum_t'(25 * 255);

  // riu2 code for patterns with more than two transitions
  localparam code_t CODE_NONUNI = code_t'(9);

  // a uniform pattern has at most this many 0/1 transitions
  localparam int UNI_MAX_TRANS = 2;

endpackage

/* rtl/nird_geom_pkg.sv */
package nird_geom_pkg;

  // image and window geometry
  localparam int PIX_W = 8;
  localparam int COLS = 16;
  localparam int ROWS = 12;
  localparam int WIN = 5;
  localparam int WIN_PIX = WIN * WIN;
  localparam int COL_W = 4;
  localparam int ROW_W = 4;

  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [COL_W-1:0] col_t;
  typedef logic [ROW_W-1:0] row_t;

  localparam col_t COL_LAST = col_t'(COLS - 1);
  localparam row_t ROW_LAST = row_t'(ROWS - 1);
  // first column that completes a 5x5 window
  localparam col_t COL_FIRST_WIN = col_t'(WIN - 1);
  // last row that is only stored, never windowed
  localparam row_t ROW_LAST_FILL = row_t'(WIN - 2);

  // sample positions in the flat window, angle order 0..315 degrees
  localparam int R2_IDX[8] = '{14, 4, 2, 0, 10, 20, 22, 24};
  localparam int R1_IDX[8] = '{13, 8, 7, 6, 11, 16, 17, 18};

  typedef enum logic {
    WIN_FILL,
    WIN_RUN
  } win_state_t;

endpackage

/* rtl/nird_ni_encoder.sv */
`timescale 1ns/1ps

module nird_ni_encoder (
  input  logic                                             clk,
  input  logic                                             rst_n_i,
  input  nird_geom_pkg::pix_t [nird_geom_pkg::WIN_PIX-1:0] win_pix_i,
  input  logic                                             win_valid_i,
  input  logic                                             win_last_i,
  output nird_code_pkg::pat_t                              ni_pat_o,
  output logic                                             ni_valid_o,
  output logic                                             ni_last_o
);

  nird_code_pkg::sum_t sum_d;
  nird_code_pkg::sum_t sum_q;
  nird_geom_pkg::pix_t s2_q [nird_code_pkg::PAT_W];
  nird_code_pkg::pat_t pat_d;
  logic                v1_q;
  logic                l1_q;

  // patch sum over all 25 pixels
  always_comb begin
    sum_d = '0;
    for (int i = 0; i < nird_geom_pkg::WIN_PIX; i++) begin
      sum_d = sum_d + nird_code_pkg::sum_t'(win_pix_i[i]);
    end
  end

  // stage 1: sum and radius-2 samples
  always_ff @(posedge clk) begin
    sum_q <= sum_d;
    for (int k = 0; k < nird_code_pkg::PAT_W; k++) begin
      s2_q[k] <= win_pix_i[nird_geom_pkg::R2_IDX[k]];
    end
  end

  // scaled sample against the sum, avoids a divide by 25
  always_comb begin
    for (int k = 0; k < nird_code_pkg::PAT_W; k++) begin
      pat_d[k] = (nird_code_pkg::GAIN * nird_code_pkg::sum_t'(s2_q[k])) >= sum_q;
    end
  end

  // stage 2: pattern
  always_ff @(posedge clk) begin
    ni_pat_o <= pat_d;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      v1_q       <= 1'b0;
      l1_q       <= 1'b0;
      ni_valid_o <= 1'b0;
      ni_last_o  <= 1'b0;
    end else begin
      v1_q       <= win_valid_i;
      l1_q       <= win_last_i;
      ni_valid_o <= v1_q;
      ni_last_o  <= l1_q;
    end
  end

  a_sum_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    v1_q |-> sum_q <= nird_code_pkg::SUM_MAX)
    else $error("patch sum out of range");

endmodule

/* rtl/nird_rd_encoder.sv */
`timescale 1ns/1ps

module nird_rd_encoder (
  input  logic                                             clk,
  input  logic                                             rst_n_i,
  input  nird_geom_pkg::pix_t [nird_geom_pkg::WIN_PIX-1:0] win_pix_i,
  input  logic                                             win_valid_i,
  input  logic                                             win_last_i,
  output nird_code_pkg::pat_t                              rd_pat_o,
  output logic                                             rd_valid_o,
  output logic                                             rd_last_o
);

  nird_geom_pkg::pix_t s2_q [nird_code_pkg::PAT_W];
  nird_geom_pkg::pix_t s1_q [nird_code_pkg::PAT_W];
  logic                v1_q;
  logic                l1_q;

  // stage 1: outer and inner ring samples at each angle
  always_ff @(posedge clk) begin
    for (int k = 0; k < nird_code_pkg::PAT_W; k++) begin
      s2_q[k] <= win_pix_i[nird_geom_pkg::R2_IDX[k]];
      s1_q[k] <= win_pix_i[nird_geom_pkg::R1_IDX[k]];
    end
  end

  // stage 2: radial comparisons, same depth as the NI path
  always_ff @(posedge clk) begin
    for (int k = 0; k < nird_code_pkg::PAT_W; k++) begin
      rd_pat_o[k] <= (s2_q[k] >= s1_q[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      v1_q       <= 1'b0;
      l1_q       <= 1'b0;
      rd_valid_o <= 1'b0;
      rd_last_o  <= 1'b0;
    end else begin
      v1_q       <= win_valid_i;
      l1_q       <= win_last_i;
      rd_valid_o <= v1_q;
      rd_last_o  <= l1_q;
    end
  end

endmodule

/* rtl/nird_riu2_map.sv */
`timescale 1ns/1ps

module nird_riu2_map (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  nird_code_pkg::pat_t   ni_pat_i,
  input  logic                  ni_valid_i,
  input  logic                  ni_last_i,
  input  nird_code_pkg::pat_t   rd_pat_i,
  input  logic                  rd_valid_i,
  output nird_code_pkg::code_t  ni_code_o,
  output nird_code_pkg::code_t  rd_code_o,
  output logic                  code_valid_o,
  output logic                  frame_done_o
);

  // rotation-invariant uniform code of one circular pattern
  function automatic nird_code_pkg::code_t riu2(input nird_code_pkg::pat_t pat);
    nird_code_pkg::code_t trans;
    nird_code_pkg::code_t ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < nird_code_pkg::PAT_W; k++) begin
      // neighbour wraps from 315 back to 0 degrees
      trans = trans + nird_code_pkg::code_t'(pat[k] ^ pat[(k+1)%nird_code_pkg::PAT_W]);
      ones  = ones + nird_code_pkg::code_t'(pat[k]);
    end
    if (trans <= nird_code_pkg::code_t'(nird_code_pkg::UNI_MAX_TRANS)) begin
      return ones;
    end
    return nird_code_pkg::CODE_NONUNI;
  endfunction

  always_ff @(posedge clk) begin
    ni_code_o <= riu2(ni_pat_i);
    rd_code_o <= riu2(rd_pat_i);
  end

  // NI strobes stand for both paths
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      code_valid_o <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      code_valid_o <= ni_valid_i;
      frame_done_o <= ni_valid_i && ni_last_i;
    end
  end

  a_valid_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    ni_valid_i == rd_valid_i)
    else $error("NI and RD encoder valids out of step");

  a_code_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    code_valid_o |-> (ni_code_o <= nird_code_pkg::CODE_NONUNI) &&
                     (rd_code_o <= nird_code_pkg::CODE_NONUNI))
    else $error("riu2 code above 9");

endmodule

/* rtl/nird_top.sv */
`timescale 1ns/1ps

module nird_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  nird_geom_pkg::pix_t   pixel_i,
  input  logic                  pixel_valid_i,
  output nird_code_pkg::code_t  ni_code_o,
  output nird_code_pkg::code_t  rd_code_o,
  output logic                  code_valid_o,
  output logic                  frame_done_o
);

  nird_geom_pkg::pix_t [nird_geom_pkg::WIN_PIX-1:0] win_pix;
  logic                                             win_valid;
  logic                                             win_last;

  nird_code_pkg::pat_t ni_pat;
  logic                ni_valid;
  logic                ni_last;
  nird_code_pkg::pat_t rd_pat;
  logic                rd_valid;

  nird_window u_window (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .win_pix_o     (win_pix),
    .win_valid_o   (win_valid),
    .win_last_o    (win_last)
  );

  nird_ni_encoder u_ni_encoder (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .win_pix_i   (win_pix),
    .win_valid_i (win_valid),
    .win_last_i  (win_last),
    .ni_pat_o    (ni_pat),
    .ni_valid_o  (ni_valid),
    .ni_last_o   (ni_last)
  );

  // frame end follows the NI path, so the RD last flag stays open
  nird_rd_encoder u_rd_encoder (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .win_pix_i   (win_pix),
    .win_valid_i (win_valid),
    .win_last_i  (win_last),
    .rd_pat_o    (rd_pat),
    .rd_valid_o  (rd_valid),
    .rd_last_o   ()
  );

  nird_riu2_map u_riu2_map (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ni_pat_i     (ni_pat),
    .ni_valid_i   (ni_valid),
    .ni_last_i    (ni_last),
    .rd_pat_i     (rd_pat),
    .rd_valid_i   (rd_valid),
    .ni_code_o    (ni_code_o),
    .rd_code_o    (rd_code_o),
    .code_valid_o (code_valid_o),
    .frame_done_o (frame_done_o)
  );

endmodule

/* rtl/nird_window.sv */
`timescale 1ns/1ps

module nird_window (
  input  logic                                                 clk,
  input  logic                                                 rst_n_i,
  input  nird_geom_pkg::pix_t                                  pixel_i,
  input  logic                                                 pixel_valid_i,
  output nird_geom_pkg::pix_t [nird_geom_pkg::WIN_PIX-1:0]     win_pix_o,
  output logic                                                 win_valid_o,
  output logic                                                 win_last_o
);

  // four stored rows with index 0 the oldest
  nird_geom_pkg::pix_t line_mem [nird_geom_pkg::WIN-1][nird_geom_pkg::COLS];

  // 5x5 window as [row][col] with col 4 the newest
  nird_geom_pkg::pix_t win_q [nird_geom_pkg::WIN][nird_geom_pkg::WIN];

  nird_geom_pkg::pix_t new_col [nird_geom_pkg::WIN];

  nird_geom_pkg::col_t       col_q;
  nird_geom_pkg::row_t       row_q;
  nird_geom_pkg::win_state_t state_q;

  logic col_end;
  logic row_end;

  assign col_end = (col_q == nird_geom_pkg::COL_LAST);
  assign row_end = (row_q == nird_geom_pkg::ROW_LAST);

  // column entering the window this pixel
  always_comb begin
    for (int r = 0; r < nird_geom_pkg::WIN - 1; r++) begin
      new_col[r] = line_mem[r][col_q];
    end
    new_col[nird_geom_pkg::WIN-1] = pixel_i;
  end

  // line buffer cascade and window shift
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int r = 0; r < nird_geom_pkg::WIN; r++) begin
        for (int c = 0; c < nird_geom_pkg::WIN - 1; c++) begin
          win_q[r][c] <= win_q[r][c+1];
        end
        win_q[r][nird_geom_pkg::WIN-1] <= new_col[r];
      end
      for (int k = 0; k < nird_geom_pkg::WIN - 2; k++) begin
        line_mem[k][col_q] <= line_mem[k+1][col_q];
      end
      line_mem[nird_geom_pkg::WIN-2][col_q] <= pixel_i;
    end
  end

  always_comb begin
    for (int r = 0; r < nird_geom_pkg::WIN; r++) begin
      for (int c = 0; c < nird_geom_pkg::WIN; c++) begin
        win_pix_o[r*nird_geom_pkg::WIN+c] = win_q[r][c];
      end
    end
  end

  // raster counters and fill state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      col_q       <= '0;
      row_q       <= '0;
      state_q     <= nird_geom_pkg::WIN_FILL;
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= pixel_valid_i && (state_q == nird_geom_pkg::WIN_RUN) &&
                     (col_q >= nird_geom_pkg::COL_FIRST_WIN);
      win_last_o  <= pixel_valid_i && col_end && row_end;
      if (pixel_valid_i) begin
        if (col_end) begin
          col_q <= '0;
          row_q <= row_end ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
        case (state_q)
          nird_geom_pkg::WIN_FILL: begin
            if (col_end && row_q == nird_geom_pkg::ROW_LAST_FILL) begin
              state_q <= nird_geom_pkg::WIN_RUN;
            end
          end
          default: begin
            // frame complete so refill for the next one
            if (col_end && row_end) begin
              state_q <= nird_geom_pkg::WIN_FILL;
            end
          end
        endcase
      end
    end
  end

  // a window only comes from a pixel below the four fill rows
  a_no_win_in_fill: assert property (@(posedge clk) disable iff (!rst_n_i)
    win_valid_o |-> $past(row_q) > nird_geom_pkg::ROW_LAST_FILL)
    else $error("window valid raised from a fill-state pixel");

endmodule
